/* execute.f */
+incdir+verilog
verilog/execute_pkg.sv
verilog/fu_branch.sv
verilog/fu_alu.sv
verilog/fu_scalar_ls.sv
verilog/fu_matrix_ls.sv
verilog/execute.sv
testbench/execute_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= execute.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/execute_tb.sv */
// Self-checking execute stage testbench; memories are modeled only by their hit signals
`timescale 1ns/1ps
`include "execute_defines.svh"

module execute_tb
    import execute_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    // About twice the length of the test sequence
    localparam int MAX_CYCLES = 2000;
    localparam int ALU_RUNS   = 200;
    localparam int BTB_RUNS   = 120;
    localparam int SLS_RUNS   = 40;
    localparam int MLS_RUNS   = 25;

    logic                CLK;
    logic                arst_n;
    logic                ihit;
    logic [`WORD_W-1:0]  imm;
    logic                bfu_update_btb;
    logic                bfu_branch_outcome;
    logic [`WORD_W-1:0]  bfu_pc;
    logic [`WORD_W-1:0]  bfu_pc_fetch;
    logic [`WORD_W-1:0]  bfu_branch_target;
    logic                bfu_hit;
    logic                bfu_pred_outcome;
    logic [`WORD_W-1:0]  bfu_pred_target;
    aluop_t              salu_aluop;
    logic [`WORD_W-1:0]  salu_port_a;
    logic [`WORD_W-1:0]  salu_port_b;
    logic [`WORD_W-1:0]  salu_port_output;
    logic                salu_negative;
    logic                salu_overflow;
    logic                salu_zero;
    mem_type_t           sls_mem_type;
    logic [`WORD_W-1:0]  sls_rs1;
    logic [`WORD_W-1:0]  sls_rs2;
    logic [`WORD_W-1:0]  sls_dmem_in;
    logic                sls_dhit_in;
    logic [`WORD_W-1:0]  sls_dmemaddr;
    logic [`WORD_W-1:0]  sls_dmemstore;
    logic [`WORD_W-1:0]  sls_dmemload;
    logic                sls_dmemREN;
    logic                sls_dmemWEN;
    logic                sls_dhit;
    logic                mls_enable;
    logic                mls_mhit;
    logic                mls_ls_in;
    logic [`MREG_W-1:0]  mls_rd_in;
    logic [`WORD_W-1:0]  mls_rs_in;
    logic [`WORD_W-1:0]  mls_stride_in;
    logic [`WORD_W-1:0]  mls_imm_in;
    logic                mls_done;
    logic                mls_ls_out;
    logic [`MREG_W-1:0]  mls_rd_out;
    logic [`WORD_W-1:0]  mls_address;
    logic [`WORD_W-1:0]  mls_stride_out;

    // Reference model state
    logic                   exp_dhit;
    logic [`WORD_W-1:0]     exp_dmemload;
    logic                   mls_pending;
    logic                   exp_done;
    logic                   exp_ls;
    logic [`MREG_W-1:0]     exp_rd;
    logic [`WORD_W-1:0]     exp_addr;
    logic [`WORD_W-1:0]     exp_stride;
    logic                   sh_valid [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0]  sh_tag   [`BTB_ENTRIES];
    logic [`WORD_W-1:0]     sh_target[`BTB_ENTRIES];
    logic [1:0]             sh_cnt   [`BTB_ENTRIES];
    logic [`BTB_IDX_W-1:0]  sh_idx;
    logic [`BTB_TAG_W-1:0]  sh_tag_in;
    logic [31:0]            lfsr_state;
    int                     cycle_count = 0;

    execute uut (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            report_failure($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    // Quarter period past the falling edge
    task automatic settle();
        #(CLK_PERIOD / 4);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Scalar LS model with completion one cycle after the hit edge
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            exp_dhit     <= 1'b0;
            exp_dmemload <= '0;
        end else begin
            exp_dhit <= sls_dhit_in && (sls_mem_type == MEM_LOAD || sls_mem_type == MEM_STORE);
            if (sls_dhit_in && sls_mem_type == MEM_LOAD) begin
                exp_dmemload <= sls_dmem_in;
            end
        end
    end

    // Matrix LS model with one pending request
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mls_pending <= 1'b0;
            exp_done    <= 1'b0;
            exp_ls      <= 1'b0;
            exp_rd      <= '0;
            exp_addr    <= '0;
            exp_stride  <= '0;
        end else begin
            exp_done <= mls_pending && mls_mhit;
            if (mls_enable && !mls_pending) begin
                mls_pending <= 1'b1;
                exp_ls      <= mls_ls_in;
                exp_rd      <= mls_rd_in;
                exp_addr    <= mls_rs_in + mls_imm_in;
                exp_stride  <= mls_stride_in;
            end else if (mls_pending && mls_mhit) begin
                mls_pending <= 1'b0;
            end
        end
    end

    // Shadow BTB
    assign sh_idx    = bfu_pc[`BTB_IDX_W+1:2];
    assign sh_tag_in = bfu_pc[`WORD_W-1:`BTB_IDX_W+2];

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                sh_valid[i] <= 1'b0;
            end
        end else if (bfu_update_btb && ihit) begin
            sh_target[sh_idx] <= bfu_branch_target;
            if (sh_valid[sh_idx] && sh_tag[sh_idx] == sh_tag_in) begin
                if (bfu_branch_outcome) begin
                    sh_cnt[sh_idx] <= (sh_cnt[sh_idx] == 2'd3) ? 2'd3 : sh_cnt[sh_idx] + 2'd1;
                end else begin
                    sh_cnt[sh_idx] <= (sh_cnt[sh_idx] == 2'd0) ? 2'd0 : sh_cnt[sh_idx] - 2'd1;
                end
            end else begin
                sh_valid[sh_idx] <= 1'b1;
                sh_tag[sh_idx]   <= sh_tag_in;
                sh_cnt[sh_idx]   <= bfu_branch_outcome ? 2'd2 : 2'd1;
            end
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge CLK) begin
        check_bit("sls_dhit", exp_dhit, sls_dhit);
        check_word("sls_dmemload", exp_dmemload, sls_dmemload);
        check_bit("mls_done", exp_done, mls_done);
        check_bit("mls_ls_out", exp_ls, mls_ls_out);
        check_word("mls_rd_out", 32'(exp_rd), 32'(mls_rd_out));
        check_word("mls_address", exp_addr, mls_address);
        check_word("mls_stride_out", exp_stride, mls_stride_out);
    end

    sls_dhit_pulse: assert property (@(negedge CLK) sls_dhit |=> !sls_dhit)
        else report_failure("sls_dhit stayed high for more than one cycle");
    mls_done_pulse: assert property (@(negedge CLK) mls_done |=> !mls_done)
        else report_failure("mls_done stayed high for more than one cycle");

    task automatic alu_ref(input aluop_t op, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] res, output logic ovf);
        longint sa;
        longint sb;
        longint wide;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        wide = 0;
        res  = '0;
        ovf  = 1'b0;
        case (op)
            ALU_ADD: begin
                wide = sa + sb;
                res  = wide[31:0];
                ovf  = (wide > 64'sh7fffffff) || (wide < -64'sh80000000);
            end
            ALU_SUB: begin
                wide = sa - sb;
                res  = wide[31:0];
                ovf  = (wide > 64'sh7fffffff) || (wide < -64'sh80000000);
            end
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            default:  res = '0;
        endcase
    endtask

    task automatic alu_case(input aluop_t op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        logic        ovf;
        @(negedge CLK);
        salu_aluop  = op;
        salu_port_a = a;
        salu_port_b = b;
        settle();
        alu_ref(op, a, b, res, ovf);
        check_word("salu_port_output", res, salu_port_output);
        check_bit("salu_zero", res == 32'd0, salu_zero);
        check_bit("salu_negative", res[31], salu_negative);
        check_bit("salu_overflow", ovf, salu_overflow);
    endtask

    task automatic check_lookup(input logic [31:0] pc);
        logic [`BTB_IDX_W-1:0] idx;
        logic                  exp_hit;
        idx     = pc[`BTB_IDX_W+1:2];
        exp_hit = sh_valid[idx] && (sh_tag[idx] == pc[`WORD_W-1:`BTB_IDX_W+2]);
        check_bit("bfu_hit", exp_hit, bfu_hit);
        if (exp_hit) begin
            check_word("bfu_pred_target", sh_target[idx], bfu_pred_target);
            check_bit("bfu_pred_outcome", sh_cnt[idx][1], bfu_pred_outcome);
        end
    endtask

    task automatic btb_step(input logic [31:0] pc, input logic outcome, input logic ih);
        @(negedge CLK);
        bfu_update_btb     = 1'b1;
        bfu_pc             = pc;
        bfu_branch_outcome = outcome;
        bfu_branch_target  = rand_bits(30) << 2;
        ihit               = ih;
        @(negedge CLK);
        bfu_update_btb = 1'b0;
        ihit           = 1'b1;
        bfu_pc_fetch   = pc;
        settle();
        check_lookup(pc);
    endtask

    task automatic sls_access(input mem_type_t t);
        int wait_cycles;
        @(negedge CLK);
        sls_mem_type = t;
        sls_rs1      = rand_bits(32);
        sls_rs2      = rand_bits(32);
        imm          = rand_bits(32);
        settle();
        check_word("sls_dmemaddr", sls_rs1 + imm, sls_dmemaddr);
        check_word("sls_dmemstore", sls_rs2, sls_dmemstore);
        check_bit("sls_dmemREN", t == MEM_LOAD, sls_dmemREN);
        check_bit("sls_dmemWEN", t == MEM_STORE, sls_dmemWEN);
        wait_cycles = rand_bits(3) % 6;
        repeat (wait_cycles) @(negedge CLK);
        @(negedge CLK);
        sls_dhit_in = 1'b1;
        sls_dmem_in = rand_bits(32);
        @(negedge CLK);
        sls_dhit_in  = 1'b0;
        sls_mem_type = MEM_NONE;
        while (!sls_dhit) @(negedge CLK);
    endtask

    task automatic mls_load_inputs();
        mls_ls_in     = rand_bits(1) != 0;
        mls_rd_in     = 4'(rand_bits(4));
        mls_rs_in     = rand_bits(32);
        mls_stride_in = rand_bits(32);
        mls_imm_in    = rand_bits(32);
    endtask

    task automatic mls_request(input logic second_enable);
        int wait_cycles;
        @(negedge CLK);
        mls_enable = 1'b1;
        mls_load_inputs();
        @(negedge CLK);
        mls_enable  = 1'b0;
        wait_cycles = rand_bits(3) % 6;
        repeat (wait_cycles) @(negedge CLK);
        // Enable while busy is dropped
        if (second_enable) begin
            mls_enable = 1'b1;
            mls_load_inputs();
            @(negedge CLK);
            mls_enable = 1'b0;
        end
        mls_mhit = 1'b1;
        @(negedge CLK);
        mls_mhit = 1'b0;
        while (!mls_done) @(negedge CLK);
    endtask

    initial begin
        logic [31:0]           pc;
        logic [31:0]           sat_pc;
        logic [`BTB_TAG_W-1:0] tag_a;
        logic [`BTB_TAG_W-1:0] tag_b;
        lfsr_state         = 32'h4bfbdb13;
        arst_n             = 1'b0;
        ihit               = 1'b1;
        imm                = '0;
        bfu_update_btb     = 1'b0;
        bfu_branch_outcome = 1'b0;
        bfu_pc             = '0;
        bfu_pc_fetch       = '0;
        bfu_branch_target  = '0;
        salu_aluop         = ALU_ADD;
        salu_port_a        = '0;
        salu_port_b        = '0;
        sls_mem_type       = MEM_NONE;
        sls_rs1            = '0;
        sls_rs2            = '0;
        sls_dmem_in        = '0;
        sls_dhit_in        = 1'b0;
        mls_enable         = 1'b0;
        mls_mhit           = 1'b0;
        mls_ls_in          = 1'b0;
        mls_rd_in          = '0;
        mls_rs_in          = '0;
        mls_stride_in      = '0;
        mls_imm_in         = '0;

        repeat (10) begin
            @(negedge CLK);
            bfu_pc_fetch = rand_bits(32);
            settle();
            check_bit("bfu_hit", 1'b0, bfu_hit);
            check_bit("sls_dhit", 1'b0, sls_dhit);
            check_bit("mls_done", 1'b0, mls_done);
        end
        @(negedge CLK);
        arst_n       = 1'b1;
        bfu_pc_fetch = rand_bits(32);
        settle();
        check_bit("bfu_hit", 1'b0, bfu_hit);

        for (int i = 0; i < ALU_RUNS; i++) begin
            alu_case(aluop_t'(4'(i % 10)), rand_bits(32), rand_bits(32));
        end
        alu_case(ALU_ADD, 32'h7fffffff, 32'h00000001);
        alu_case(ALU_ADD, 32'h80000000, 32'h80000000);
        alu_case(ALU_SUB, 32'h80000000, 32'h00000001);
        alu_case(ALU_SUB, 32'h7fffffff, 32'hffffffff);
        alu_case(ALU_SUB, 32'h1234abcd, 32'h1234abcd);

        // Drive one counter to both saturation limits
        sat_pc = rand_bits(32) & 32'hffff_fffc;
        repeat (5) btb_step(sat_pc, 1'b1, 1'b1);
        repeat (5) btb_step(sat_pc, 1'b0, 1'b1);
        btb_step(sat_pc ^ 32'h0000_1000, 1'b1, 1'b0);
        // Two tags over four indexes force aliasing
        tag_a = 26'(rand_bits(26));
        tag_b = 26'(rand_bits(26));
        for (int i = 0; i < BTB_RUNS; i++) begin
            pc = {(rand_bits(1) != 0) ? tag_a : tag_b, 2'b00, 2'(rand_bits(2)), 2'b00};
            btb_step(pc, rand_bits(1) != 0, rand_bits(3) != 0);
        end

        for (int i = 0; i < SLS_RUNS; i++) begin
            sls_access((rand_bits(1) != 0) ? MEM_LOAD : MEM_STORE);
        end

        for (int i = 0; i < MLS_RUNS; i++) begin
            // Stray hit while idle
            if (rand_bits(2) == 0) begin
                @(negedge CLK);
                mls_mhit = 1'b1;
                @(negedge CLK);
                mls_mhit = 1'b0;
            end
            mls_request(rand_bits(2) == 0);
        end

        repeat (2) @(negedge CLK);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog/execute.sv */
// Execute stage top level; memories and register files are outside and only their hits come in
`timescale 1ns/1ps
`include "execute_defines.svh"

module execute
    import execute_pkg::*;
(
    input  logic                CLK,
    input  logic                arst_n,
    input  logic                ihit,
    input  logic [`WORD_W-1:0]  imm,
    // Branch unit
    input  logic                bfu_update_btb,
    input  logic                bfu_branch_outcome,
    input  logic [`WORD_W-1:0]  bfu_pc,
    input  logic [`WORD_W-1:0]  bfu_pc_fetch,
    input  logic [`WORD_W-1:0]  bfu_branch_target,
    output logic                bfu_hit,
    output logic                bfu_pred_outcome,
    output logic [`WORD_W-1:0]  bfu_pred_target,
    // Scalar ALU
    input  aluop_t              salu_aluop,
    input  logic [`WORD_W-1:0]  salu_port_a,
    input  logic [`WORD_W-1:0]  salu_port_b,
    output logic [`WORD_W-1:0]  salu_port_output,
    output logic                salu_negative,
    output logic                salu_overflow,
    output logic                salu_zero,
    // Scalar load/store
    input  mem_type_t           sls_mem_type,
    input  logic [`WORD_W-1:0]  sls_rs1,
    input  logic [`WORD_W-1:0]  sls_rs2,
    input  logic [`WORD_W-1:0]  sls_dmem_in,
    input  logic                sls_dhit_in,
    output logic [`WORD_W-1:0]  sls_dmemaddr,
    output logic [`WORD_W-1:0]  sls_dmemstore,
    output logic [`WORD_W-1:0]  sls_dmemload,
    output logic                sls_dmemREN,
    output logic                sls_dmemWEN,
    output logic                sls_dhit,
    // Matrix load/store
    input  logic                mls_enable,
    input  logic                mls_mhit,
    input  logic                mls_ls_in,
    input  logic [`MREG_W-1:0]  mls_rd_in,
    input  logic [`WORD_W-1:0]  mls_rs_in,
    input  logic [`WORD_W-1:0]  mls_stride_in,
    input  logic [`WORD_W-1:0]  mls_imm_in,
    output logic                mls_done,
    output logic                mls_ls_out,
    output logic [`MREG_W-1:0]  mls_rd_out,
    output logic [`WORD_W-1:0]  mls_address,
    output logic [`WORD_W-1:0]  mls_stride_out
);

    fu_branch bfu (
        .CLK(CLK), .arst_n(arst_n), .ihit(ihit),
        .update_btb(bfu_update_btb), .branch_outcome(bfu_branch_outcome),
        .pc(bfu_pc), .pc_fetch(bfu_pc_fetch), .branch_target(bfu_branch_target),
        .hit(bfu_hit), .pred_outcome(bfu_pred_outcome), .pred_target(bfu_pred_target)
    );

    fu_alu salu (
        .aluop(salu_aluop), .port_a(salu_port_a), .port_b(salu_port_b),
        .port_output(salu_port_output), .negative(salu_negative),
        .overflow(salu_overflow), .zero(salu_zero)
    );

    // Offset is the shared immediate
    fu_scalar_ls sls (
        .CLK(CLK), .arst_n(arst_n), .mem_type(sls_mem_type), .imm(imm),
        .rs1(sls_rs1), .rs2(sls_rs2), .dmem_in(sls_dmem_in), .dhit_in(sls_dhit_in),
        .dmemaddr(sls_dmemaddr), .dmemstore(sls_dmemstore), .dmemload(sls_dmemload),
        .dmemREN(sls_dmemREN), .dmemWEN(sls_dmemWEN), .dhit(sls_dhit)
    );

    fu_matrix_ls mls (
        .CLK(CLK), .arst_n(arst_n), .enable(mls_enable), .mhit(mls_mhit),
        .ls_in(mls_ls_in), .rd_in(mls_rd_in), .rs_in(mls_rs_in),
        .stride_in(mls_stride_in), .imm_in(mls_imm_in), .done(mls_done),
        .ls_out(mls_ls_out), .rd_out(mls_rd_out), .address(mls_address),
        .stride_out(mls_stride_out)
    );

endmodule

/* verilog/fu_matrix_ls.sv */
// Matrix load/store holds one request at a time; enable while busy is dropped, not queued
`timescale 1ns/1ps
`include "execute_defines.svh"

module fu_matrix_ls (
    input  logic                CLK,
    input  logic                arst_n,
    input  logic                enable,
    input  logic                mhit,
    input  logic                ls_in,
    input  logic [`MREG_W-1:0]  rd_in,
    input  logic [`WORD_W-1:0]  rs_in,
    input  logic [`WORD_W-1:0]  stride_in,
    input  logic [`WORD_W-1:0]  imm_in,
    output logic                done,
    output logic                ls_out,
    output logic [`MREG_W-1:0]  rd_out,
    output logic [`WORD_W-1:0]  address,
    output logic [`WORD_W-1:0]  stride_out
);

    logic busy;
    logic capture;
    logic finish;

    assign capture = enable && !busy;
    assign finish  = busy && mhit;

    // Outstanding request flag and done pulse
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= finish;
            if (capture) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // Request register held until the next capture
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ls_out     <= 1'b0;
            rd_out     <= '0;
            address    <= '0;
            stride_out <= '0;
        end else if (capture) begin
            ls_out     <= ls_in;
            rd_out     <= rd_in;
            // Effective base address of the matrix
            address    <= rs_in + imm_in;
            stride_out <= stride_in;
        end
    end

endmodule

/* verilog/fu_scalar_ls.sv */
// Scalar load/store; request must be held until dhit_in, and dhit follows one cycle later
`timescale 1ns/1ps
`include "execute_defines.svh"

module fu_scalar_ls
    import execute_pkg::*;
(
    input  logic                CLK,
    input  logic                arst_n,
    input  mem_type_t           mem_type,
    input  logic [`WORD_W-1:0]  imm,
    input  logic [`WORD_W-1:0]  rs1,
    input  logic [`WORD_W-1:0]  rs2,
    input  logic [`WORD_W-1:0]  dmem_in,
    input  logic                dhit_in,
    output logic [`WORD_W-1:0]  dmemaddr,
    output logic [`WORD_W-1:0]  dmemstore,
    output logic [`WORD_W-1:0]  dmemload,
    output logic                dmemREN,
    output logic                dmemWEN,
    output logic                dhit
);

    logic is_load;
    logic is_store;

    assign is_load  = (mem_type == MEM_LOAD);
    assign is_store = (mem_type == MEM_STORE);

    // Base plus offset with no alignment check
    assign dmemaddr  = rs1 + imm;
    assign dmemstore = rs2;
    assign dmemREN   = is_load;
    assign dmemWEN   = is_store;

    // Load data is captured at the hit edge
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dmemload <= '0;
        end else if (dhit_in && is_load) begin
            dmemload <= dmem_in;
        end
    end

    // Completion pulse one cycle after the hit
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dhit <= 1'b0;
        end else begin
            dhit <= dhit_in && (is_load || is_store);
        end
    end

endmodule

/* verilog/fu_alu.sv */
// Combinational scalar ALU; shifts use port_b[4:0] and overflow is only defined for add and sub
`timescale 1ns/1ps
`include "execute_defines.svh"

module fu_alu
    import execute_pkg::*;
(
    input  aluop_t              aluop,
    input  logic [`WORD_W-1:0]  port_a,
    input  logic [`WORD_W-1:0]  port_b,
    output logic [`WORD_W-1:0]  port_output,
    output logic                negative,
    output logic                overflow,
    output logic                zero
);

    always_comb begin
        port_output = '0;
        overflow    = 1'b0;
        case (aluop)
            ALU_ADD: begin
                port_output = port_a + port_b;
                // Same-sign operands with a sign change in the sum
                overflow = (port_a[`WORD_W-1] == port_b[`WORD_W-1]) &&
                           (port_output[`WORD_W-1] != port_a[`WORD_W-1]);
            end
            ALU_SUB: begin
                port_output = port_a - port_b;
                overflow = (port_a[`WORD_W-1] != port_b[`WORD_W-1]) &&
                           (port_output[`WORD_W-1] != port_a[`WORD_W-1]);
            end
            ALU_AND: port_output = port_a & port_b;
            ALU_OR:  port_output = port_a | port_b;
            ALU_XOR: port_output = port_a ^ port_b;
            ALU_SLL: port_output = port_a << port_b[4:0];
            ALU_SRL: port_output = port_a >> port_b[4:0];
            ALU_SRA: port_output = $signed(port_a) >>> port_b[4:0];
            ALU_SLT: begin
                port_output = {{(`WORD_W-1){1'b0}}, $signed(port_a) < $signed(port_b)};
            end
            ALU_SLTU: begin
                port_output = {{(`WORD_W-1){1'b0}}, port_a < port_b};
            end
            default: begin
                port_output = '0;
                overflow    = 1'b0;
            end
        endcase
    end

    // Flags follow the result
    assign zero     = (port_output == '0);
    assign negative = port_output[`WORD_W-1];

endmodule

/* verilog/fu_branch.sv */
// Direct-mapped 16-entry BTB; lookup is combinational and updates only land when ihit is high
`timescale 1ns/1ps
`include "execute_defines.svh"

module fu_branch (
    input  logic                CLK,
    input  logic                arst_n,
    input  logic                ihit,
    input  logic                update_btb,
    input  logic                branch_outcome,
    input  logic [`WORD_W-1:0]  pc,
    input  logic [`WORD_W-1:0]  pc_fetch,
    input  logic [`WORD_W-1:0]  branch_target,
    output logic                hit,
    output logic                pred_outcome,
    output logic [`WORD_W-1:0]  pred_target
);

    logic                   valid   [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0]  tags    [`BTB_ENTRIES];
    logic [`WORD_W-1:0]     targets [`BTB_ENTRIES];
    logic [1:0]             counters[`BTB_ENTRIES];

    logic [`BTB_IDX_W-1:0]  upd_idx;
    logic [`BTB_TAG_W-1:0]  upd_tag;
    logic [`BTB_IDX_W-1:0]  fetch_idx;
    logic [`BTB_TAG_W-1:0]  fetch_tag;
    logic                   upd_en;
    logic                   upd_match;

    // Word-aligned pcs, so bits 1:0 are not part of index or tag
    assign upd_idx   = pc[`BTB_IDX_W+1:2];
    assign upd_tag   = pc[`WORD_W-1:`BTB_IDX_W+2];
    assign fetch_idx = pc_fetch[`BTB_IDX_W+1:2];
    assign fetch_tag = pc_fetch[`WORD_W-1:`BTB_IDX_W+2];

    assign upd_en    = update_btb && ihit;
    assign upd_match = valid[upd_idx] && (tags[upd_idx] == upd_tag);

    // Lookup
    assign hit          = valid[fetch_idx] && (tags[fetch_idx] == fetch_tag);
    assign pred_target  = targets[fetch_idx];
    assign pred_outcome = counters[fetch_idx][1];

    // Entry valid bits
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (upd_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (upd_en) begin
            targets[upd_idx] <= branch_target;
            if (upd_match) begin
                // Saturating step toward the resolved outcome
                if (branch_outcome && counters[upd_idx] != 2'd3) begin
                    counters[upd_idx] <= counters[upd_idx] + 2'd1;
                end else if (!branch_outcome && counters[upd_idx] != 2'd0) begin
                    counters[upd_idx] <= counters[upd_idx] - 2'd1;
                end
            end else begin
                // Replacement starts weakly biased toward the outcome
                tags[upd_idx]     <= upd_tag;
                counters[upd_idx] <= branch_outcome ? 2'd2 : 2'd1;
            end
        end
    end

endmodule

/* verilog/execute_pkg.sv */
// Operation and memory request encodings; values are fixed and shared with the testbench
package execute_pkg;

    // Scalar ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluop_t;

    // Scalar memory request kind
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

endpackage

/* verilog/execute_defines.svh */
// Widths and sizes for the execute stage; BTB index and tag split assume WORD_W of 32
`ifndef EXECUTE_DEFINES_SVH
`define EXECUTE_DEFINES_SVH

// Data and address width
`define WORD_W 32

// Branch target buffer geometry
`define BTB_ENTRIES 16

// Index comes from pc[5:2]
`define BTB_IDX_W 4

// Tag is the rest of the pc above the index
`define BTB_TAG_W 26

// Matrix register number
`define MREG_W 4

`endif
